//--- source/otp_chk_defs.svh
// Check scheduler parameters

`ifndef OTP_CHK_DEFS_SVH
`define OTP_CHK_DEFS_SVH

// Partitions that receive check requests
`define OTP_NUM_PART 4

// Width of the LFSR and of both check counters
`define OTP_LFSR_WIDTH 40

// Entropy word delivered by the entropy source
`define OTP_EDN_WIDTH 64

// Draws before fresh entropy is requested
`define OTP_RESEED_THRESHOLD 4

// Power-on LFSR state, must be nonzero
`define OTP_LFSR_SEED 40'h5A_C3E1_94B7

`endif

//--- source/otp_ext_pkg.sv
// External interface types

`include "otp_chk_defs.svh"

package otp_ext_pkg;

  // Life-cycle escalation encoding
  // Anything other than LcOff is treated as active
  typedef enum logic [3:0] {
    LcOn  = 4'b1010,
    LcOff = 4'b0101
  } lc_tx_e;

  // Response from the entropy source
  // Ack is a single-cycle pulse, data valid with it
  typedef struct packed {
    logic                      ack;
    logic [`OTP_EDN_WIDTH-1:0] data;
  } edn_rsp_t;

endpackage

//--- source/otp_chk_pkg.sv
// Check scheduler types

package otp_chk_pkg;

  // Scheduler FSM states
  typedef enum logic [2:0] {
    ResetSt,
    IdleSt,
    IntegWaitSt,
    CnstyWaitSt,
    ErrorSt
  } chk_state_e;

  // Kind of check issued to the partitions
  typedef enum logic {
    ChkInteg = 1'b0,
    ChkCnsty = 1'b1
  } chk_kind_e;

  // Software configuration, a zero mask disables that periodic check
  typedef struct packed {
    logic [31:0] timeout;
    logic [31:0] integ_msk;
    logic [31:0] cnsty_msk;
  } chk_cfg_t;

  // Sequencer to tracker
  typedef struct packed {
    logic      start;
    chk_kind_e start_kind;
    logic      clr_integ_trig;
    logic      clr_cnsty_trig;
  } chk_cmd_t;

  // Tracker to sequencer
  typedef struct packed {
    logic integ_done;
    logic cnsty_done;
    logic integ_trig;
    logic cnsty_trig;
  } chk_trk_t;

endpackage

//--- source/otp_chk_lfsr.sv
// Redundant random period source

`timescale 1ns/1ps

`include "otp_chk_defs.svh"

module otp_chk_lfsr (
  input  logic                       clk_i,
  input  logic                       rst_ni,
  input  logic                       draw_i,
  input  otp_ext_pkg::edn_rsp_t      edn_i,
  output logic                       edn_req_o,
  output logic [`OTP_LFSR_WIDTH-1:0] state_o,
  output logic                       err_o
);

  localparam int W = `OTP_LFSR_WIDTH;
  localparam int CntW = $clog2(`OTP_RESEED_THRESHOLD + 1);
  // Galois feedback for x^40 + x^38 + x^21 + x^19 + 1
  localparam logic [W-1:0] Taps = 40'hA0_0014_0000;
  localparam logic [W-1:0] Seed = `OTP_LFSR_SEED;

  ////////////////////
  // Reseed tracking
  ////////////////////

  logic [CntW-1:0] reseed_cnt_q;
  logic            reseed_en;

  // Request is held until the entropy ack arrives
  assign edn_req_o = (reseed_cnt_q >= CntW'(`OTP_RESEED_THRESHOLD));
  assign reseed_en = edn_req_o & edn_i.ack;

  // Counting freezes while the request is out, draws still go through
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      reseed_cnt_q <= '0;
    end else if (reseed_en) begin
      reseed_cnt_q <= '0;
    end else if (draw_i && !edn_req_o) begin
      reseed_cnt_q <= reseed_cnt_q + 1'b1;
    end
  end

  ////////////////////
  // Tandem LFSR
  ////////////////////

  logic [W-1:0] lfsr_a_q, lfsr_b_q;
  logic [W-1:0] entropy;

  // Fresh bits only mixed in on the reseed cycle
  assign entropy = reseed_en ? edn_i.data[W-1:0] : '0;

  function automatic logic [W-1:0] lfsr_step(input logic [W-1:0] s, input logic [W-1:0] ent);
    logic [W-1:0] nxt;
    nxt = (s >> 1) ^ ({W{s[0]}} & Taps) ^ ent;
    // Escape the all-zero lockup state
    if (nxt == '0) begin
      nxt = Seed;
    end
    return nxt;
  endfunction

  // Both copies advance together
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      lfsr_a_q <= Seed;
      lfsr_b_q <= Seed;
    end else if (draw_i || reseed_en) begin
      lfsr_a_q <= lfsr_step(lfsr_a_q, entropy);
      lfsr_b_q <= lfsr_step(lfsr_b_q, entropy);
    end
  end

  assign state_o = lfsr_a_q;
  // Any disagreement means a fault was injected
  assign err_o   = (lfsr_a_q != lfsr_b_q);

endmodule

//--- source/otp_chk_tandem_cnt.sv
// Redundant down-counter

`timescale 1ns/1ps

module otp_chk_tandem_cnt #(
  parameter int Width = 40
) (
  input  logic             clk_i,
  input  logic             rst_ni,
  input  logic             set_i,
  input  logic [Width-1:0] set_val_i,
  input  logic             dec_i,
  output logic [Width-1:0] cnt_o,
  output logic             zero_o,
  output logic             err_o
);

  logic [Width-1:0] cnt_q;
  // Shadow holds the bitwise complement of cnt_q
  logic [Width-1:0] shadow_q;

  // Load wins over decrement, decrement stops at zero
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      cnt_q    <= '0;
      shadow_q <= '1;
    end else if (set_i) begin
      cnt_q    <= set_val_i;
      shadow_q <= ~set_val_i;
    end else if (dec_i && !zero_o) begin
      cnt_q    <= cnt_q - 1'b1;
      // ~(x - 1) equals ~x + 1
      shadow_q <= shadow_q + 1'b1;
    end
  end

  assign cnt_o  = cnt_q;
  assign zero_o = (cnt_q == '0);
  assign err_o  = (cnt_q != ~shadow_q);

endmodule

//--- source/otp_chk_req_tracker.sv
// Partition request tracker

`timescale 1ns/1ps

`include "otp_chk_defs.svh"

module otp_chk_req_tracker (
  input  logic                     clk_i,
  input  logic                     rst_ni,
  input  otp_chk_pkg::chk_cmd_t    cmd_i,
  input  logic                     integ_trig_i,
  input  logic                     cnsty_trig_i,
  input  logic [`OTP_NUM_PART-1:0] integ_ack_i,
  input  logic [`OTP_NUM_PART-1:0] cnsty_ack_i,
  output logic [`OTP_NUM_PART-1:0] integ_req_o,
  output logic [`OTP_NUM_PART-1:0] cnsty_req_o,
  output otp_chk_pkg::chk_trk_t    trk_o
);

  import otp_chk_pkg::*;

  logic [`OTP_NUM_PART-1:0] integ_req_q, cnsty_req_q;
  logic                     integ_trig_q, cnsty_trig_q;
  logic                     start_integ, start_cnsty;

  assign start_integ = cmd_i.start && (cmd_i.start_kind == ChkInteg);
  assign start_cnsty = cmd_i.start && (cmd_i.start_kind == ChkCnsty);

  ////////////////////
  // Requests
  ////////////////////

  // Start raises all bits of one kind, each ack drops its own bit
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      integ_req_q  <= '0;
      cnsty_req_q  <= '0;
      integ_trig_q <= 1'b0;
      cnsty_trig_q <= 1'b0;
    end else begin
      integ_req_q  <= start_integ ? '1 : (integ_req_q & ~integ_ack_i);
      cnsty_req_q  <= start_cnsty ? '1 : (cnsty_req_q & ~cnsty_ack_i);
      // Sticky one-off triggers, a new pulse beats a clear
      integ_trig_q <= (integ_trig_q & ~cmd_i.clr_integ_trig) | integ_trig_i;
      cnsty_trig_q <= (cnsty_trig_q & ~cmd_i.clr_cnsty_trig) | cnsty_trig_i;
    end
  end

  assign integ_req_o = integ_req_q;
  assign cnsty_req_o = cnsty_req_q;

  // Done when every partition has answered
  assign trk_o.integ_done = (integ_req_q == '0);
  assign trk_o.cnsty_done = (cnsty_req_q == '0);
  assign trk_o.integ_trig = integ_trig_q;
  assign trk_o.cnsty_trig = cnsty_trig_q;

endmodule

//--- source/otp_chk_sequencer.sv
// Check sequencer FSM

`timescale 1ns/1ps

`include "otp_chk_defs.svh"

module otp_chk_sequencer (
  input  logic                       clk_i,
  input  logic                       rst_ni,
  input  logic                       timer_en_i,
  input  logic                       otp_prog_busy_i,
  input  otp_chk_pkg::chk_cfg_t      cfg_i,
  input  otp_ext_pkg::lc_tx_e        escalate_i,
  input  logic [`OTP_LFSR_WIDTH-1:0] lfsr_state_i,
  input  logic                       lfsr_err_i,
  input  otp_chk_pkg::chk_trk_t      trk_i,
  output logic                       draw_o,
  output otp_chk_pkg::chk_cmd_t      cmd_o,
  output logic                       chk_pending_o,
  output logic                       chk_timeout_o,
  output logic                       fsm_err_o
);

  import otp_chk_pkg::*;
  import otp_ext_pkg::*;

  localparam int W = `OTP_LFSR_WIDTH;

  chk_state_e state_d, state_q;
  logic       chk_timeout_d, chk_timeout_q;
  logic       integ_set_period, integ_set_timeout, integ_zero, integ_err;
  logic       cnsty_set_period, cnsty_set_timeout, cnsty_zero, cnsty_err;
  logic       cnsty_pause;
  logic [W-1:0] timeout_val, integ_set_val, cnsty_set_val;

  ////////////////////
  // Counters
  ////////////////////

  assign timeout_val = {{(W-32){1'b0}}, cfg_i.timeout};
  // Low byte always open, so a period is at least 0..255
  assign integ_set_val = integ_set_period ? (lfsr_state_i & {cfg_i.integ_msk, 8'hFF})
                                          : timeout_val;
  assign cnsty_set_val = cnsty_set_period ? (lfsr_state_i & {cfg_i.cnsty_msk, 8'hFF})
                                          : timeout_val;

  otp_chk_tandem_cnt #(.Width(W)) u_integ_cnt (
    .clk_i     (clk_i),
    .rst_ni    (rst_ni),
    .set_i     (integ_set_period | integ_set_timeout),
    .set_val_i (integ_set_val),
    .dec_i     (1'b1),
    .cnt_o     (),
    .zero_o    (integ_zero),
    .err_o     (integ_err)
  );

  // Consistency countdown holds while programming is busy
  otp_chk_tandem_cnt #(.Width(W)) u_cnsty_cnt (
    .clk_i     (clk_i),
    .rst_ni    (rst_ni),
    .set_i     (cnsty_set_period | cnsty_set_timeout),
    .set_val_i (cnsty_set_val),
    .dec_i     (!cnsty_pause),
    .cnt_o     (),
    .zero_o    (cnsty_zero),
    .err_o     (cnsty_err)
  );

  ////////////////////
  // FSM
  ////////////////////

  always_comb begin
    state_d           = state_q;
    chk_timeout_d     = chk_timeout_q;
    draw_o            = 1'b0;
    integ_set_period  = 1'b0;
    integ_set_timeout = 1'b0;
    cnsty_set_period  = 1'b0;
    cnsty_set_timeout = 1'b0;
    cnsty_pause       = 1'b0;
    cmd_o             = '{start: 1'b0, start_kind: ChkInteg,
                          clr_integ_trig: 1'b0, clr_cnsty_trig: 1'b0};
    chk_pending_o     = trk_i.integ_trig | trk_i.cnsty_trig;
    fsm_err_o         = 1'b0;

    case (state_q)
      // Leave only once, first period drawn on the way out
      ResetSt: begin
        if (timer_en_i) begin
          state_d = IdleSt;
          draw_o  = 1'b1;
        end
      end
      // Integrity has priority over consistency
      IdleSt: begin
        if ((cfg_i.integ_msk != '0 && integ_zero) || trk_i.integ_trig) begin
          state_d                  = IntegWaitSt;
          integ_set_timeout        = 1'b1;
          cmd_o.start              = 1'b1;
          cmd_o.start_kind         = ChkInteg;
          cmd_o.clr_integ_trig     = trk_i.integ_trig;
        end else if ((cfg_i.cnsty_msk != '0 && cnsty_zero) || trk_i.cnsty_trig) begin
          state_d                  = CnstyWaitSt;
          cnsty_set_timeout        = 1'b1;
          cmd_o.start              = 1'b1;
          cmd_o.start_kind         = ChkCnsty;
          cmd_o.clr_cnsty_trig     = trk_i.cnsty_trig;
        end
      end
      // Timeout only armed when nonzero
      IntegWaitSt: begin
        chk_pending_o = 1'b1;
        if (cfg_i.timeout != '0 && integ_zero) begin
          state_d       = ErrorSt;
          chk_timeout_d = 1'b1;
        end else if (trk_i.integ_done) begin
          state_d          = IdleSt;
          integ_set_period = 1'b1;
          draw_o           = 1'b1;
        end
      end
      CnstyWaitSt: begin
        chk_pending_o = 1'b1;
        cnsty_pause   = otp_prog_busy_i;
        if (cfg_i.timeout != '0 && cnsty_zero) begin
          state_d       = ErrorSt;
          chk_timeout_d = 1'b1;
        end else if (trk_i.cnsty_done) begin
          state_d          = IdleSt;
          cnsty_set_period = 1'b1;
          draw_o           = 1'b1;
        end
      end
      // Terminal, pending triggers are flushed forever
      ErrorSt: begin
        cmd_o.clr_integ_trig = 1'b1;
        cmd_o.clr_cnsty_trig = 1'b1;
        fsm_err_o            = !chk_timeout_q;
      end
      default: begin
        state_d   = ErrorSt;
        fsm_err_o = 1'b1;
      end
    endcase

    // Redundancy faults and escalation act immediately
    if (lfsr_err_i || integ_err || cnsty_err || escalate_i != LcOff) begin
      state_d   = ErrorSt;
      fsm_err_o = 1'b1;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q       <= ResetSt;
      chk_timeout_q <= 1'b0;
    end else begin
      state_q       <= state_d;
      chk_timeout_q <= chk_timeout_d;
    end
  end

  assign chk_timeout_o = chk_timeout_q;

endmodule

//--- source/otp_chk_timer_top.sv
// Check scheduler top level

`timescale 1ns/1ps

`include "otp_chk_defs.svh"

module otp_chk_timer_top (
  input  logic                     clk_i,
  input  logic                     rst_ni,
  input  otp_chk_pkg::chk_cfg_t    cfg_i,
  input  logic                     timer_en_i,
  input  logic                     otp_prog_busy_i,
  input  logic                     integ_trig_i,
  input  logic                     cnsty_trig_i,
  output logic [`OTP_NUM_PART-1:0] integ_req_o,
  output logic [`OTP_NUM_PART-1:0] cnsty_req_o,
  input  logic [`OTP_NUM_PART-1:0] integ_ack_i,
  input  logic [`OTP_NUM_PART-1:0] cnsty_ack_i,
  output logic                     edn_req_o,
  input  otp_ext_pkg::edn_rsp_t    edn_i,
  input  otp_ext_pkg::lc_tx_e      escalate_i,
  output logic                     chk_pending_o,
  output logic                     chk_timeout_o,
  output logic                     fsm_err_o
);

  import otp_chk_pkg::*;

  logic                       draw;
  logic [`OTP_LFSR_WIDTH-1:0] lfsr_state;
  logic                       lfsr_err;
  chk_cmd_t                   cmd;
  chk_trk_t                   trk;

  // Random period source
  otp_chk_lfsr u_lfsr (
    .clk_i     (clk_i),
    .rst_ni    (rst_ni),
    .draw_i    (draw),
    .edn_i     (edn_i),
    .edn_req_o (edn_req_o),
    .state_o   (lfsr_state),
    .err_o     (lfsr_err)
  );

  // Partition requests and trigger latches
  otp_chk_req_tracker u_req_tracker (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .cmd_i        (cmd),
    .integ_trig_i (integ_trig_i),
    .cnsty_trig_i (cnsty_trig_i),
    .integ_ack_i  (integ_ack_i),
    .cnsty_ack_i  (cnsty_ack_i),
    .integ_req_o  (integ_req_o),
    .cnsty_req_o  (cnsty_req_o),
    .trk_o        (trk)
  );

  otp_chk_sequencer u_sequencer (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .timer_en_i      (timer_en_i),
    .otp_prog_busy_i (otp_prog_busy_i),
    .cfg_i           (cfg_i),
    .escalate_i      (escalate_i),
    .lfsr_state_i    (lfsr_state),
    .lfsr_err_i      (lfsr_err),
    .trk_i           (trk),
    .draw_o          (draw),
    .cmd_o           (cmd),
    .chk_pending_o   (chk_pending_o),
    .chk_timeout_o   (chk_timeout_o),
    .fsm_err_o       (fsm_err_o)
  );

endmodule

//--- verification/tb_clk_gen.sv
// Testbench clock source

`timescale 1ns/1ps

module tb_clk_gen #(
  parameter real PeriodNs = 4.0
) (
  output logic clk_o
);

  // Free running, starts low
  initial begin
    clk_o = 1'b0;
    forever #(PeriodNs / 2.0) clk_o = ~clk_o;
  end

endmodule

//--- verification/tb_otp_chk_timer.sv
// Check scheduler testbench

`timescale 1ns/1ps

`include "otp_chk_defs.svh"

module tb_otp_chk_timer;

  import otp_chk_pkg::*;
  import otp_ext_pkg::*;

  localparam int NP = `OTP_NUM_PART;
  localparam int Timeout = 20;
  // Longest period 511 plus handshake slack
  localparam int MaxGap = 517;
  // About 2300 cycles of phases plus margin
  localparam int MaxCycles = 4000;

  logic          clk, rst_n, timer_en, busy, integ_trig, cnsty_trig;
  chk_cfg_t      cfg;
  edn_rsp_t      edn;
  lc_tx_e        escalate;
  logic [NP-1:0] integ_req, cnsty_req, integ_ack, cnsty_ack;
  logic          edn_req, pending, chk_timeout, fsm_err;

  // Partition model state
  logic [NP-1:0][3:0] integ_dly, cnsty_dly;
  logic               integ_ack_en, cnsty_ack_en;
  logic [31:0]        rnd_state = 32'd76466;

  // Phase enables for the checks
  logic trig_en, quiet_en, period_en, to_en, pause_en, esc_en;
  int   cycles, draws, gap, to_cnt, since_busy;
  logic started, to_seen, to_checked, prev_busy;

  tb_clk_gen u_clk_gen (.clk_o(clk));

  otp_chk_timer_top otp_chk_timer_top_inst (
    .clk_i           (clk),
    .rst_ni          (rst_n),
    .cfg_i           (cfg),
    .timer_en_i      (timer_en),
    .otp_prog_busy_i (busy),
    .integ_trig_i    (integ_trig),
    .cnsty_trig_i    (cnsty_trig),
    .integ_req_o     (integ_req),
    .cnsty_req_o     (cnsty_req),
    .integ_ack_i     (integ_ack),
    .cnsty_ack_i     (cnsty_ack),
    .edn_req_o       (edn_req),
    .edn_i           (edn),
    .escalate_i      (escalate),
    .chk_pending_o   (pending),
    .chk_timeout_o   (chk_timeout),
    .fsm_err_o       (fsm_err)
  );

  task automatic report_failure(input string msg);
    $display("%s", msg);
    $display("Some tests failed");
    $fatal(1);
  endtask

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  ////////////////////
  // Partition model
  ////////////////////

  // Each raised bit waits a random 1..8 cycles before a one-cycle ack
  task automatic step_acks(input logic [NP-1:0] req, input logic en,
                           inout logic [NP-1:0][3:0] dly, inout logic [NP-1:0] ack);
    for (int i = 0; i < NP; i++) begin
      if (!req[i] || ack[i] || !en) begin
        ack[i] = 1'b0;
        dly[i] = 4'd0;
      end else if (dly[i] == 4'd0) begin
        rnd_state = xorshift32(rnd_state);
        dly[i] = 4'd1 + {1'b0, rnd_state[2:0]};
      end else begin
        dly[i] = dly[i] - 4'd1;
        ack[i] = (dly[i] == 4'd0);
      end
    end
  endtask

  initial begin
    integ_ack = '0;
    cnsty_ack = '0;
    integ_dly = '0;
    cnsty_dly = '0;
    forever begin
      @(posedge clk);
      #1;
      if (!rst_n) begin
        integ_ack = '0;
        cnsty_ack = '0;
        integ_dly = '0;
        cnsty_dly = '0;
      end else begin
        step_acks(integ_req, integ_ack_en, integ_dly, integ_ack);
        step_acks(cnsty_req, cnsty_ack_en, cnsty_dly, cnsty_ack);
      end
    end
  end

  ////////////////////
  // Concurrent checks
  ////////////////////

  // Trigger at edge N gives all requests after N+2
  assert property (@(posedge clk) disable iff (!rst_n)
      trig_en && integ_trig && !cnsty_trig |-> ##2 (integ_req == '1 && pending))
    else report_failure($sformatf("[ERROR] integ_req_o=%h chk_pending_o=%h expected %h 1",
                                  integ_req, pending, {NP{1'b1}}));
  assert property (@(posedge clk) disable iff (!rst_n)
      trig_en && cnsty_trig && !integ_trig |-> ##2 (cnsty_req == '1 && pending))
    else report_failure($sformatf("[ERROR] cnsty_req_o=%h chk_pending_o=%h expected %h 1",
                                  cnsty_req, pending, {NP{1'b1}}));
  // Integrity wins when both fire together
  assert property (@(posedge clk) disable iff (!rst_n)
      trig_en && integ_trig && cnsty_trig |-> ##2 (integ_req == '1 && cnsty_req == '0))
    else report_failure($sformatf("[ERROR] integ_req_o=%h cnsty_req_o=%h expected %h 0",
                                  integ_req, cnsty_req, {NP{1'b1}}));
  assert property (@(posedge clk) disable iff (!rst_n)
      cnsty_req != '0 |-> integ_req == '0)
    else report_failure($sformatf("[ERROR] integ_req_o=%h expected 0 while cnsty_req_o=%h",
                                  integ_req, cnsty_req));
  // An ack drops its bit at the next edge
  assert property (@(posedge clk) disable iff (!rst_n)
      (integ_req & integ_ack) != '0 |=> (integ_req & $past(integ_ack)) == '0)
    else report_failure($sformatf("[ERROR] integ_req_o=%h still set after ack", integ_req));
  assert property (@(posedge clk) disable iff (!rst_n)
      (cnsty_req & cnsty_ack) != '0 |=> (cnsty_req & $past(cnsty_ack)) == '0)
    else report_failure($sformatf("[ERROR] cnsty_req_o=%h still set after ack", cnsty_req));
  assert property (@(posedge clk) disable iff (!rst_n)
      edn_req && edn.ack |=> !edn_req)
    else report_failure($sformatf("[ERROR] edn_req_o=%h expected 0", edn_req));
  // Escalation flags an error at once and Error issues no requests
  assert property (@(posedge clk) disable iff (!rst_n)
      escalate != LcOff |-> fsm_err)
    else report_failure($sformatf("[ERROR] fsm_err_o=%h expected 1", fsm_err));
  assert property (@(posedge clk) disable iff (!rst_n)
      esc_en |-> (integ_req == '0 && cnsty_req == '0 && fsm_err))
    else report_failure($sformatf("[ERROR] integ_req_o=%h cnsty_req_o=%h fsm_err_o=%h",
                                  integ_req, cnsty_req, fsm_err));
  assert property (@(posedge clk) disable iff (!rst_n)
      chk_timeout |-> !fsm_err)
    else report_failure($sformatf("[ERROR] fsm_err_o=%h expected 0", fsm_err));

  ////////////////////
  // Counting checks
  ////////////////////

  // Falling edge lies between drive and capture
  always @(negedge clk) begin
    if (!rst_n) begin
      draws      = 0;
      gap        = 0;
      to_cnt     = 0;
      since_busy = 0;
      started    = 1'b0;
      to_seen    = 1'b0;
      to_checked = 1'b0;
      prev_busy  = 1'b0;
    end else begin
      assert (edn_req == (draws >= `OTP_RESEED_THRESHOLD))
        else report_failure($sformatf("[ERROR] edn_req_o=%h expected %h (draws %0d)",
                                      edn_req, draws >= `OTP_RESEED_THRESHOLD, draws));
      // Draw on leaving reset state and on each completed check
      if (edn_req && edn.ack) begin
        draws = 0;
      end else if (!edn_req && ((timer_en && !started) ||
                                (prev_busy && integ_req == '0 && cnsty_req == '0))) begin
        draws++;
      end
      started   = started | timer_en;
      prev_busy = (integ_req != '0) || (cnsty_req != '0);
      gap = (integ_req != '0) ? 0 : gap + 1;
      if (period_en) begin
        assert (gap <= MaxGap)
          else report_failure($sformatf("Integrity checks more than %0d cycles apart", MaxGap));
      end
      if (quiet_en) begin
        assert (integ_req == '0 && cnsty_req == '0)
          else report_failure($sformatf("[ERROR] integ_req_o=%h cnsty_req_o=%h expected 0",
                                        integ_req, cnsty_req));
      end
      // Timeout measured from the first visible request
      if (to_en) begin
        if (to_seen) begin
          to_cnt++;
        end
        to_seen = to_seen | (integ_req != '0);
      end
      since_busy = busy ? 0 : since_busy + 1;
      if (chk_timeout && !to_checked) begin
        to_checked = 1'b1;
        if (to_en) begin
          assert (to_seen && to_cnt >= Timeout + 1 && to_cnt <= Timeout + 3)
            else report_failure($sformatf("Timeout came %0d cycles after the requests", to_cnt));
        end
        if (pause_en) begin
          assert (since_busy >= Timeout)
            else report_failure("Consistency timeout ran while programming was busy");
        end
      end
    end
  end

  always @(posedge clk) begin
    cycles++;
    if (cycles >= MaxCycles) begin
      report_failure("Run did not finish within the cycle limit");
    end
  end

  ////////////////////
  // Stimulus
  ////////////////////

  task automatic cycle(input int n);
    repeat (n) begin
      @(posedge clk);
      #1;
    end
  endtask

  task automatic apply_reset();
    rst_n    = 1'b0;
    timer_en = 1'b0;
    busy     = 1'b0;
    escalate = LcOff;
    cycle(2);
    rst_n = 1'b1;
  endtask

  task automatic pulse_trig(input logic i, input logic c);
    integ_trig = i;
    cnsty_trig = c;
    cycle(1);
    integ_trig = 1'b0;
    cnsty_trig = 1'b0;
  endtask

  // Wait until no request or trigger is outstanding
  task automatic wait_quiet();
    cycle(3);
    while (integ_req != '0 || cnsty_req != '0 || pending) begin
      cycle(1);
    end
  endtask

  task automatic wait_timeout();
    while (!chk_timeout) begin
      cycle(1);
    end
  endtask

  initial begin
    cycles = 0;
    rst_n = 1'b0;
    timer_en = 1'b0;
    busy = 1'b0;
    integ_trig = 1'b0;
    cnsty_trig = 1'b0;
    cfg = '0;
    edn = '0;
    escalate = LcOff;
    integ_ack_en = 1'b1;
    cnsty_ack_en = 1'b1;
    {trig_en, quiet_en, period_en, to_en, pause_en, esc_en} = '0;
    apply_reset();

    // No check may start while both masks are zero
    timer_en = 1'b1;
    quiet_en = 1'b1;
    cycle(300);
    quiet_en = 1'b0;

    // Single triggers followed by both at once
    trig_en = 1'b1;
    pulse_trig(1'b1, 1'b0);
    wait_quiet();
    pulse_trig(1'b0, 1'b1);
    wait_quiet();
    pulse_trig(1'b1, 1'b1);
    wait_quiet();
    trig_en = 1'b0;

    // Periodic integrity checks with a reseed served midway
    cfg.integ_msk = 32'd1;
    period_en = 1'b1;
    cycle(700);
    edn.data = 64'h3C5A_96E1_0F87_D24B;
    edn.ack = 1'b1;
    cycle(1);
    edn.ack = 1'b0;
    cycle(900);
    period_en = 1'b0;

    // Unanswered integrity check runs into the timeout
    cfg = '0;
    apply_reset();
    cfg.timeout = Timeout;
    timer_en = 1'b1;
    integ_ack_en = 1'b0;
    to_en = 1'b1;
    cycle(2);
    pulse_trig(1'b1, 1'b0);
    wait_timeout();
    cycle(2);
    to_en = 1'b0;

    // Busy programming holds the consistency timeout
    apply_reset();
    integ_ack_en = 1'b1;
    cnsty_ack_en = 1'b0;
    timer_en = 1'b1;
    busy = 1'b1;
    pause_en = 1'b1;
    cycle(2);
    pulse_trig(1'b0, 1'b1);
    cycle(40);
    busy = 1'b0;
    wait_timeout();
    cycle(2);
    pause_en = 1'b0;

    // Escalation locks the scheduler
    cfg.timeout = '0;
    apply_reset();
    cnsty_ack_en = 1'b1;
    timer_en = 1'b1;
    cycle(3);
    escalate = LcOn;
    cycle(1);
    esc_en = 1'b1;
    cycle(2);
    pulse_trig(1'b1, 1'b1);
    cycle(10);

    $display("All tests passed");
    $finish;
  end

endmodule

//--- otp_chk_timer_top.f
+incdir+source
source/otp_ext_pkg.sv
source/otp_chk_pkg.sv
source/otp_chk_lfsr.sv
source/otp_chk_tandem_cnt.sv
source/otp_chk_req_tracker.sv
source/otp_chk_sequencer.sv
source/otp_chk_timer_top.sv
verification/tb_clk_gen.sv
verification/tb_otp_chk_timer.sv

//--- Makefile
SIM  = obj_dir/Vtb_otp_chk_timer
SRCS = $(shell grep -v '^+' otp_chk_timer_top.f) source/otp_chk_defs.svh

all: run

$(SIM): otp_chk_timer_top.f $(SRCS)
	verilator --binary --timing --assert --top-module tb_otp_chk_timer -f otp_chk_timer_top.f

run: $(SIM)
	./$(SIM) | awk '{ print } /All tests passed/ { ok = 1 } END { exit !ok }'

clean:
	rm -rf obj_dir

.PHONY: all run clean
